/* fetch_trace_top.f */
rtl/mem_pkg.sv
rtl/uart_pkg.sv
rtl/mmu_if.sv
rtl/program_memory.sv
rtl/mmu_translate.sv
rtl/uart_tx.sv
rtl/uart_tx_buffer.sv
rtl/fetch_control.sv
rtl/fetch_trace_top.sv
testbench/fetch_trace_checker.sv
testbench/fetch_trace_tb.sv

/* testbench/fetch_trace_stim.txt */
// kind_a_b_c, 48 bits: 01 word a=addr c=data | 02 map a=seg,next c=page
// 03 run a=start_pc b=seg,..,rand c=end_pc | 04 pair a=pc b=w1 c=w2 | 05 go c=fault
01_00_0000_4110
01_01_0000_1234
01_02_0000_4220
01_03_0000_5678
01_5D_0000_4330
01_5E_0000_9ABC
01_5F_0000_4440
01_70_0000_DEF0
01_71_0000_4550
01_72_0000_0F1E
01_7E_0000_4660
01_7F_0000_1357
// chain 3 -> 7 -> 5, pages 0, 2, 1
02_37_0000_0000
02_75_0000_0002
02_55_0000_0001
// page 0 only, executor always ready
03_00_0000_0004
04_00_4110_1234
04_02_4220_5678
05_00_0000_0000
// same run, random executor_ready
03_00_0001_0004
04_00_4110_1234
04_02_4220_5678
05_00_0000_0000
// pages 1 and 2 through the chain, one pair straddles a page
03_1D_3001_0023
04_1D_4330_9ABC
04_1F_4440_DEF0
04_21_4550_0F1E
05_00_0000_0000
// page 3 is missing, fault after one pair
03_2E_3001_0034
04_2E_4660_1357
05_00_0000_0001

/* testbench/fetch_trace_tb.sv */
`timescale 1ns/1ps

module fetch_trace_tb import mem_pkg::*, uart_pkg::*;;

  localparam int BIT_CLKS    = 8;   // fast uart for simulation
  localparam int STIM_DEPTH  = 64;

  logic  clk = 1'b0;
  logic  reset, prog_write, map_write, run, executor_ready;
  addr_t prog_addr, start_pc, end_pc, exec_pc;
  word_t prog_data, instruction1, instruction2;
  seg_t  map_segment, map_next, start_segment;
  page_t map_page;
  logic  exec, busy, mmu_fault, tx;

  logic [47:0] stim [STIM_DEPTH];   // kind, a, b, c
  addr_t exp_pc [$];                // pairs still to come
  word_t exp_w1 [$];
  word_t exp_w2 [$];
  char_t exp_chars [$];             // trace characters still to come
  logic        random_ready;
  logic [31:0] rng_state = 32'd42;
  int          cycles = 0;
  int          cycle_limit;

  fetch_trace_top #(
    .MMU_PAGE_WORDS(16), .CLKS_PER_BIT(BIT_CLKS), .TRACE_DEPTH(4)
  ) uut (.*);

  bind fetch_control fetch_trace_checker checks (
    .clk(clk), .reset(reset), .exec(exec), .executor_ready(executor_ready),
    .mmu_fault(mmu_fault), .push(push), .full(full)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "stopped on first error");
  endtask

  task automatic load_word(input addr_t addr, input word_t data);
    @(posedge clk);
    prog_write <= 1'b1;
    prog_addr  <= addr;
    prog_data  <= data;
    @(posedge clk);
    prog_write <= 1'b0;
  endtask

  task automatic load_map(input seg_t seg, input seg_t next, input page_t page);
    @(posedge clk);
    map_write   <= 1'b1;
    map_segment <= seg;
    map_next    <= next;
    map_page    <= page;
    @(posedge clk);
    map_write <= 1'b0;
  endtask

  // pulse run, then hold until busy drops
  task automatic run_to_end(input seg_t seg, input addr_t first, input addr_t last,
                            input logic rnd);
    @(posedge clk);
    start_segment <= seg;
    start_pc      <= first;
    end_pc        <= last;
    random_ready  <= rnd;
    run           <= 1'b1;
    @(posedge clk);
    run <= 1'b0;
    do @(posedge clk); while (busy);
  endtask

  // executor_ready steady or from the lcg
  always @(posedge clk) begin
    if (random_ready) begin
      rng_state = lcg_step(rng_state);
      executor_ready <= rng_state[17:16] != 2'b00;  // ready about 3 of 4 cycles
    end else begin
      executor_ready <= 1'b1;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit)
      report_failure($sformatf("timeout after %0d cycles, run never finished", cycles));
  end

  // pair monitor
  always @(posedge clk) begin
    if (!reset) begin
      assert (uut.fetch.checks.violations == 0)
        else report_failure("a protocol assertion in the checker failed");
      if (exec) begin
        assert (exp_pc.size() != 0) else report_failure("exec with no pair left to expect");
        assert (exec_pc == exp_pc[0])
          else report_failure($sformatf("mismatch at %0t: exec_pc %h, expected %h",
                                        $time, exec_pc, exp_pc[0]));
        assert (instruction1 == exp_w1[0] && instruction2 == exp_w2[0])
          else report_failure($sformatf("mismatch at %0t: pair %h %h, expected %h %h",
                                        $time, instruction1, instruction2, exp_w1[0],
                                        exp_w2[0]));
        void'(exp_pc.pop_front());
        void'(exp_w1.pop_front());
        void'(exp_w2.pop_front());
      end
    end
  end

  // uart decoder sampling each bit at its middle
  always begin : uart_decoder
    char_t ch;
    @(negedge tx);
    repeat (BIT_CLKS / 2) @(posedge clk);
    assert (tx == 1'b0) else report_failure("start bit on tx did not hold low");
    for (int b = 0; b < 8; b++) begin
      repeat (BIT_CLKS) @(posedge clk);
      ch[b] = tx;  // lsb first
    end
    repeat (BIT_CLKS) @(posedge clk);
    assert (tx == 1'b1) else report_failure("stop bit on tx missing");
    assert (exp_chars.size() != 0) else report_failure("tx sent a character nobody expected");
    assert (ch == exp_chars[0])
      else report_failure($sformatf("mismatch at %0t: tx char %h, expected %h",
                                    $time, ch, exp_chars[0]));
    void'(exp_chars.pop_front());
  end

  initial begin
    logic [47:0] rec;
    int          n_pairs;
    int          n_recs;
    seg_t        run_seg;
    addr_t       run_first;
    addr_t       run_last;
    logic        run_rnd;
    for (int i = 0; i < STIM_DEPTH; i++) stim[i] = '0;
    $readmemh("testbench/fetch_trace_stim.txt", stim);
    n_pairs = 0;
    n_recs  = 0;
    while (n_recs < STIM_DEPTH && stim[n_recs][47:40] != 8'h00) begin
      if (stim[n_recs][47:40] == 8'h04) n_pairs++;
      n_recs++;
    end
    // each pair fetches in under 40 cycles and sends a 10-bit frame
    cycle_limit = n_pairs * (40 + 10 * BIT_CLKS) + n_recs * 4 + 20 * BIT_CLKS + 200;
    reset          = 1'b1;
    prog_write     = 1'b0;
    map_write      = 1'b0;
    run            = 1'b0;
    prog_addr      = '0;
    prog_data      = '0;
    map_segment    = '0;
    map_next       = '0;
    map_page       = '0;
    start_segment  = '0;
    start_pc       = '0;
    end_pc         = '0;
    executor_ready = 1'b0;
    random_ready   = 1'b0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    for (int i = 0; i < n_recs; i++) begin
      rec = stim[i];
      case (rec[47:40])
        8'h01: load_word(rec[39:32], rec[15:0]);
        8'h02: load_map(rec[39:36], rec[35:32], rec[3:0]);
        8'h03: begin
          run_first = rec[39:32];
          run_seg   = rec[31:28];
          run_rnd   = rec[16];
          run_last  = rec[7:0];
        end
        8'h04: begin
          exp_pc.push_back(rec[39:32]);
          exp_w1.push_back(rec[31:16]);
          exp_w2.push_back(rec[15:0]);
          exp_chars.push_back(rec[31:24]);  // trace is the high byte of word 1
        end
        8'h05: begin
          run_to_end(run_seg, run_first, run_last, run_rnd);
          assert (exp_pc.size() == 0)
            else report_failure("busy fell before every expected pair was issued");
          assert (mmu_fault == rec[0])
            else report_failure($sformatf("mismatch at %0t: mmu_fault %b, expected %b",
                                          $time, mmu_fault, rec[0]));
        end
        default: report_failure("unknown record kind in the stim file");
      endcase
    end
    while (exp_chars.size() != 0) @(posedge clk);  // frames still on the line
    repeat (12 * BIT_CLKS) @(posedge clk);         // room for a stray frame
    if (uut.fetch.checks.violations == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      report_failure("a protocol assertion in the checker failed");
    end
  end

endmodule

/* testbench/fetch_trace_checker.sv */
`timescale 1ns/1ps

// protocol rules of the fetch controller, bound into fetch_control
module fetch_trace_checker (
  input logic clk,
  input logic reset,
  input logic exec,
  input logic executor_ready,
  input logic mmu_fault,
  input logic push,
  input logic full
);

  int violations = 0;  // read by the testbench monitor

  // a pair only leaves when the executor takes it
  exec_needs_ready: assert property (@(posedge clk) disable iff (reset)
    exec |-> executor_ready)
    else begin
      $error("exec issued while executor_ready was low");
      violations++;
    end

  // faulted process stays halted
  no_exec_after_fault: assert property (@(posedge clk) disable iff (reset)
    mmu_fault |-> !exec)
    else begin
      $error("exec issued after mmu_fault");
      violations++;
    end

  no_push_when_full: assert property (@(posedge clk) disable iff (reset)
    push |-> !full)
    else begin
      $error("push into a full trace fifo");
      violations++;
    end

endmodule

/* rtl/fetch_trace_top.sv */
`timescale 1ns/1ps

module fetch_trace_top import mem_pkg::*, uart_pkg::*; #(
  parameter int MMU_PAGE_WORDS = mem_pkg::MMU_PAGE_WORDS,
  parameter int CLKS_PER_BIT   = uart_pkg::CLKS_PER_BIT,
  parameter int TRACE_DEPTH    = uart_pkg::TRACE_DEPTH
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  prog_write,      // program memory load
  input  addr_t prog_addr,
  input  word_t prog_data,
  input  logic  map_write,       // mmu table load
  input  seg_t  map_segment,
  input  seg_t  map_next,
  input  page_t map_page,
  input  seg_t  start_segment,   // first segment of the running process
  input  logic  run,
  input  addr_t start_pc,
  input  addr_t end_pc,
  input  logic  executor_ready,
  output logic  exec,
  output addr_t exec_pc,
  output word_t instruction1,
  output word_t instruction2,
  output logic  busy,
  output logic  mmu_fault,
  output logic  tx
);

  addr_t read_addr;
  word_t read_data;
  logic  push;
  char_t trace_char;
  logic  full;
  logic  tx_start;   // fifo -> serializer
  char_t tx_data;
  logic  tx_idle;

  mmu_if mmu_link ();

  fetch_control #(.MMU_PAGE_WORDS(MMU_PAGE_WORDS)) fetch (
    .clk(clk), .reset(reset), .run(run), .start_pc(start_pc), .end_pc(end_pc),
    .executor_ready(executor_ready), .mmu(mmu_link),
    .read_addr(read_addr), .read_data(read_data),
    .push(push), .char(trace_char), .full(full),
    .exec(exec), .exec_pc(exec_pc), .instruction1(instruction1),
    .instruction2(instruction2), .busy(busy), .mmu_fault(mmu_fault)
  );

  mmu_translate #(.MMU_PAGE_WORDS(MMU_PAGE_WORDS)) mmu (
    .clk(clk), .reset(reset), .map_write(map_write), .map_segment(map_segment),
    .map_next(map_next), .map_page(map_page), .start_segment(start_segment),
    .mmu(mmu_link)
  );

  program_memory prog_mem (
    .clk(clk), .prog_write(prog_write), .prog_addr(prog_addr), .prog_data(prog_data),
    .read_addr(read_addr), .read_data(read_data)
  );

  uart_tx_buffer #(.TRACE_DEPTH(TRACE_DEPTH)) trace_fifo (
    .clk(clk), .reset(reset), .push(push), .char(trace_char), .idle(tx_idle),
    .full(full), .start(tx_start), .data(tx_data)
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) serializer (
    .clk(clk), .reset(reset), .start(tx_start), .data(tx_data),
    .idle(tx_idle), .tx(tx)
  );

endmodule

/* rtl/fetch_control.sv */
`timescale 1ns/1ps

module fetch_control import mem_pkg::*, uart_pkg::*; #(
  parameter int MMU_PAGE_WORDS = mem_pkg::MMU_PAGE_WORDS
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  run,
  input  addr_t start_pc,
  input  addr_t end_pc,          // first pc not fetched
  input  logic  executor_ready,
  mmu_if.client mmu,
  output addr_t read_addr,       // physical, to program memory
  input  word_t read_data,       // one cycle after read_addr
  output logic  push,
  output char_t char,
  input  logic  full,
  output logic  exec,            // one pulse per pair
  output addr_t exec_pc,
  output word_t instruction1,
  output word_t instruction2,
  output logic  busy,
  output logic  mmu_fault        // sticky until reset
);

  typedef enum logic [3:0] {
    S_IDLE, S_NEXT, S_XLATE1, S_READ1, S_GET1,
    S_XLATE2, S_READ2, S_GET2, S_TRACE, S_ISSUE
  } state_t;

  state_t state;
  addr_t  pc;          // logical pc of the pair
  addr_t  pc_next;     // logical address of the second word
  logic   same_page;   // second word needs no new translation

  assign pc_next   = pc + addr_t'(1);
  assign same_page = (pc / MMU_PAGE_WORDS) == (pc_next / MMU_PAGE_WORDS);

  assign push    = (state == S_TRACE) && !full;  // never into a full fifo
  assign char    = instruction1[15:8];           // trace = high byte of word 1
  assign exec    = (state == S_ISSUE) && executor_ready;
  assign exec_pc = pc;                           // pc moves on after exec

  always_ff @(posedge clk) begin
    mmu.req <= 1'b0;  // pulse only
    if (reset) begin
      state     <= S_IDLE;
      busy      <= 1'b0;
      mmu_fault <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          // a faulted process stays halted
          if (run && !mmu_fault) begin
            pc    <= start_pc;
            busy  <= 1'b1;
            state <= S_NEXT;
          end
        end
        S_NEXT: begin
          if (pc < end_pc) begin
            mmu.req          <= 1'b1;
            mmu.logical_addr <= pc;
            state            <= S_XLATE1;
          end else begin
            busy  <= 1'b0;  // run complete
            state <= S_IDLE;
          end
        end
        S_XLATE1, S_XLATE2: begin
          if (mmu.fault) begin
            mmu_fault <= 1'b1;
            busy      <= 1'b0;
            state     <= S_IDLE;
          end else if (mmu.done) begin
            read_addr <= mmu.physical_addr;
            state     <= (state == S_XLATE1) ? S_READ1 : S_READ2;
          end
        end
        S_READ1: state <= S_GET1;  // memory latency
        S_GET1: begin
          instruction1 <= read_data;
          if (same_page) begin
            read_addr <= read_addr + addr_t'(1);  // next physical word
            state     <= S_READ2;
          end else begin
            mmu.req          <= 1'b1;
            mmu.logical_addr <= pc_next;
            state            <= S_XLATE2;
          end
        end
        S_READ2: state <= S_GET2;
        S_GET2: begin
          instruction2 <= read_data;
          state        <= S_TRACE;
        end
        S_TRACE: if (!full) state <= S_ISSUE;  // wait for fifo room
        S_ISSUE: begin
          if (executor_ready) begin
            pc    <= pc + addr_t'(2);
            state <= S_NEXT;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

/* rtl/uart_tx_buffer.sv */
`timescale 1ns/1ps

module uart_tx_buffer import uart_pkg::*; #(
  parameter int TRACE_DEPTH = uart_pkg::TRACE_DEPTH
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  push,     // only while full is low
  input  char_t char,
  input  logic  idle,     // serializer ready
  output logic  full,
  output logic  start,    // pops the oldest character
  output char_t data
);

  localparam int PTR_W = (TRACE_DEPTH > 1) ? $clog2(TRACE_DEPTH) : 1;
  localparam int CNT_W = $clog2(TRACE_DEPTH + 1);

  char_t            fifo [TRACE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;   // occupancy

  assign full  = count == CNT_W'(TRACE_DEPTH);
  assign start = idle && count != '0;
  assign data  = fifo[rd_ptr];

  // circular pointer step, depth need not be a power of two
  function automatic logic [PTR_W-1:0] step(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(TRACE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (push && !full) fifo[wr_ptr] <= char;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push && !full) wr_ptr <= step(wr_ptr);
      if (start) rd_ptr <= step(rd_ptr);
      case ({push && !full, start})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // none, or push and pop together
      endcase
    end
  end

endmodule

/* rtl/uart_tx.sv */
`timescale 1ns/1ps

// 8N1, LSB first, line high while idle
module uart_tx import uart_pkg::*; #(
  parameter int CLKS_PER_BIT = uart_pkg::CLKS_PER_BIT
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  start,   // taken only while idle
  input  char_t data,
  output logic  idle,
  output logic  tx
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

  logic             sending;
  logic [CNT_W-1:0] clk_cnt;    // clocks into the current bit
  logic [3:0]       bits_left;  // data bits plus stop still to go
  logic [8:0]       shift;      // stop bit above the data

  assign idle = !sending;

  always_ff @(posedge clk) begin
    if (reset) begin
      sending <= 1'b0;
      tx      <= 1'b1;
    end else if (!sending) begin
      if (start) begin
        sending   <= 1'b1;
        tx        <= 1'b0;  // start bit
        shift     <= {1'b1, data};
        bits_left <= 4'd9;
        clk_cnt   <= '0;
      end
    end else if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
      clk_cnt <= '0;
      if (bits_left == 4'd0) begin
        sending <= 1'b0;  // stop bit done, tx already high
      end else begin
        tx        <= shift[0];
        shift     <= shift >> 1;
        bits_left <= bits_left - 4'd1;
      end
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

endmodule

/* rtl/mmu_translate.sv */
`timescale 1ns/1ps

module mmu_translate import mem_pkg::*; #(
  parameter int MMU_PAGE_WORDS = mem_pkg::MMU_PAGE_WORDS
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  map_write,     // table load
  input  seg_t  map_segment,
  input  seg_t  map_next,
  input  page_t map_page,
  input  seg_t  start_segment, // sampled on req
  mmu_if.server mmu
);

  seg_t  chain_tbl [MMU_SEGMENTS];  // next segment of the process, self ends the chain
  page_t page_tbl  [MMU_SEGMENTS];  // logical page held by each segment
  seg_t  start_seg;                 // start segment of the current request
  seg_t  cur_seg;                   // segment under test
  addr_t want_addr;                 // logical address being translated
  page_t want_page;
  logic  walking;

  assign want_page = page_t'(want_addr / MMU_PAGE_WORDS);

  // segment base plus offset within the page
  function automatic addr_t phys(input seg_t seg, input addr_t addr);
    return addr_t'(seg * MMU_PAGE_WORDS + addr % MMU_PAGE_WORDS);
  endfunction

  always_ff @(posedge clk) begin
    mmu.done  <= 1'b0;
    mmu.fault <= 1'b0;
    if (reset) begin
      walking <= 1'b0;
      for (int i = 0; i < MMU_SEGMENTS; i++) begin
        chain_tbl[i] <= seg_t'(i);  // every segment alone, empty
        page_tbl[i]  <= '0;
      end
    end else begin
      if (map_write) begin
        chain_tbl[map_segment] <= map_next;
        page_tbl[map_segment]  <= map_page;
      end
      if (mmu.req) begin
        start_seg <= start_segment;
        want_addr <= mmu.logical_addr;
        if (mmu.logical_addr < MMU_PAGE_WORDS) begin
          // page 0 always lives in the start segment
          mmu.done          <= 1'b1;
          mmu.physical_addr <= phys(start_segment, mmu.logical_addr);
        end else begin
          cur_seg <= chain_tbl[start_segment];
          walking <= 1'b1;
        end
      end else if (walking) begin
        // one segment per cycle
        if (page_tbl[cur_seg] == want_page) begin
          mmu.done          <= 1'b1;
          mmu.physical_addr <= phys(cur_seg, want_addr);
          walking           <= 1'b0;
        end else if (chain_tbl[cur_seg] == cur_seg || chain_tbl[cur_seg] == start_seg) begin
          // end of chain, or looped back to the start
          mmu.fault <= 1'b1;
          walking   <= 1'b0;
        end else begin
          cur_seg <= chain_tbl[cur_seg];
        end
      end
    end
  end

endmodule

/* rtl/program_memory.sv */
`timescale 1ns/1ps

module program_memory import mem_pkg::*; (
  input  logic  clk,
  input  logic  prog_write,   // load port
  input  addr_t prog_addr,
  input  word_t prog_data,
  input  addr_t read_addr,    // physical word address
  output word_t read_data     // one cycle later
);

  // whole physical space, segment * page words + offset
  word_t mem [PROG_WORDS];

  always_ff @(posedge clk) begin
    if (prog_write) begin
      mem[prog_addr] <= prog_data;
    end
  end

  // registered read
  always_ff @(posedge clk) begin
    read_data <= mem[read_addr];
  end

endmodule

/* rtl/mmu_if.sv */
`timescale 1ns/1ps

// translate request from the fetch side, answer from the MMU
// req is a one-cycle pulse, done or fault answers with one pulse
interface mmu_if import mem_pkg::*; ();

  logic  req;            // start a translation
  addr_t logical_addr;   // held by the client until the answer
  logic  done;           // physical_addr valid this cycle
  addr_t physical_addr;
  logic  fault;          // page not in the chain

  modport client (
    output req, logical_addr,
    input  done, physical_addr, fault
  );

  modport server (
    input  req, logical_addr,
    output done, physical_addr, fault
  );

endinterface

/* rtl/uart_pkg.sv */
package uart_pkg;

  // one trace character, sent as an 8N1 frame
  typedef logic [7:0] char_t;

  // bit time in clocks, 100 MHz / 115200 baud
  parameter int CLKS_PER_BIT = 868;

  // characters the trace FIFO can hold
  parameter int TRACE_DEPTH = 8;

endpackage

/* rtl/mem_pkg.sv */
package mem_pkg;

  // instruction or data word, one per address
  typedef logic [15:0] word_t;

  // word address, the same width for logical and physical
  typedef logic [7:0] addr_t;

  // physical segment index
  typedef logic [3:0] seg_t;

  // logical page number
  // 0 marks an empty segment, except the start segment which holds page 0
  typedef logic [3:0] page_t;

  // words per page, so page = addr / MMU_PAGE_WORDS
  parameter int MMU_PAGE_WORDS = 16;

  // entries in the chain and page tables, one per segment
  parameter int MMU_SEGMENTS = 2 ** $bits(seg_t);

  // depth of the program memory, the whole physical space
  parameter int PROG_WORDS = 2 ** $bits(addr_t);

endpackage
